//--- verilog/ps2_pkg.sv
// PS/2 line-protocol constants shared by the line filter, receiver and transmitter.
// Refer to them by scoped name, for example ps2_pkg::FRAME_BITS.

`default_nettype none

package ps2_pkg;

    // bits that follow the start bit in one frame
    // 8 data bits, odd parity and the stop bit
    localparam int FRAME_BITS = 10;

    // consecutive equal samples needed before a filtered line may change
    localparam int FILTER_LEN = 4;

    // system clocks the host holds ps2_clk low before a request to send
    // this is short for simulation, real hardware wants about 100 us
    localparam int INHIBIT_CYCLES = 64;

    // width of the inhibit counter
    localparam int INHIBIT_W = $clog2(INHIBIT_CYCLES);

endpackage

`default_nettype wire

//--- verilog/kbd_pkg.sv
// Keyboard command, response and scancode constants.
// Used by the controller and the translator as kbd_pkg::name.

`default_nettype none

package kbd_pkg;

    // host to keyboard commands
    localparam logic [7:0] CMD_RESET  = 8'hFF;
    localparam logic [7:0] CMD_ENABLE = 8'hF4;

    // keyboard to host responses
    localparam logic [7:0] RSP_ACK    = 8'hFA;
    localparam logic [7:0] RSP_BAT_OK = 8'hAA;

    // set-2 prefixes for a release and for the extended keys
    localparam logic [7:0] SC_BREAK   = 8'hF0;
    localparam logic [7:0] SC_EXT     = 8'hE0;

    // translator result when a set-2 code has no set-1 entry
    localparam logic [7:0] SC1_NONE   = 8'h00;

    // set-1 bit that marks a key release
    localparam logic [7:0] BREAK_FLAG = 8'h80;

endpackage

`default_nettype wire

//--- verilog/ps2_line_filter.sv
// Input conditioning for the two PS/2 lines.
// Each pin is synchronized, then only follows a run of FILTER_LEN equal samples.
// clk_fall strobes for one cycle when the filtered clock goes low.

`timescale 1ns/1ps
`default_nettype none

module ps2_line_filter (
    input  wire  clk,
    input  wire  reset,
    input  wire  ps2_clk_in,
    input  wire  ps2_data_in,
    output logic clk_filt,
    output logic data_filt,
    output logic clk_fall
);

    // bit 0 carries the clock line and bit 1 the data line
    logic [1:0] sync1;
    logic [1:0] sync2;
    logic [1:0] filt;
    logic [$clog2(ps2_pkg::FILTER_LEN)-1:0] run_cnt [2];
    logic       clk_prev;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            // both lines idle high through their pull-ups
            sync1      <= 2'b11;
            sync2      <= 2'b11;
            filt       <= 2'b11;
            run_cnt[0] <= '0;
            run_cnt[1] <= '0;
            clk_prev   <= 1'b1;
        end else begin
            sync1    <= {ps2_data_in, ps2_clk_in};
            sync2    <= sync1;
            clk_prev <= filt[0];
            for (int i = 0; i < 2; i++) begin
                // any sample that agrees with the filtered level restarts the run
                if (sync2[i] == filt[i]) begin
                    run_cnt[i] <= '0;
                end else if (run_cnt[i] == ps2_pkg::FILTER_LEN - 1) begin
                    filt[i]    <= sync2[i];
                    run_cnt[i] <= '0;
                end else begin
                    run_cnt[i] <= run_cnt[i] + 1'b1;
                end
            end
        end
    end

    assign clk_filt  = filt[0];
    assign data_filt = filt[1];
    // high in the first cycle the filtered clock reads low
    assign clk_fall  = clk_prev & ~filt[0];

endmodule

`default_nettype wire

//--- verilog/ps2_rx.sv
// Device-to-host frame receiver.
// Bits are taken on each filtered clock falling edge, LSB first.
// rx_valid pulses for one cycle with rx_byte once parity and stop check out.

`timescale 1ns/1ps
`default_nettype none

module ps2_rx (
    input  wire        clk,
    input  wire        reset,
    input  wire        clk_fall,
    input  wire        data_filt,
    input  wire        rx_inhibit,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);

    // set once a low start bit has been seen
    logic active;
    // index of the next bit after the start bit
    logic [$clog2(ps2_pkg::FRAME_BITS)-1:0] bit_cnt;
    // running xor over data and parity, odd parity leaves it at 1
    logic parity;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active   <= 1'b0;
            bit_cnt  <= '0;
            parity   <= 1'b0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (rx_inhibit) begin
                // the host owns the bus while it transmits
                active  <= 1'b0;
                bit_cnt <= '0;
            end else if (clk_fall) begin
                if (!active) begin
                    // a high start bit is ignored and we keep waiting
                    if (!data_filt) begin
                        active  <= 1'b1;
                        bit_cnt <= '0;
                        parity  <= 1'b0;
                    end
                end else if (bit_cnt == ps2_pkg::FRAME_BITS - 1) begin
                    // stop bit must be high and the parity odd
                    active   <= 1'b0;
                    bit_cnt  <= '0;
                    rx_valid <= data_filt & parity;
                end else begin
                    parity  <= parity ^ data_filt;
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // data shifter, it stops moving after the eighth data bit
    always_ff @(posedge clk) begin
        if (clk_fall && active && !rx_inhibit &&
            bit_cnt < ps2_pkg::FRAME_BITS - 2) begin
            rx_byte <= {data_filt, rx_byte[7:1]};
        end
    end

endmodule

`default_nettype wire

//--- verilog/ps2_tx.sv
// Host-to-device command transmitter.
// Pull the clock low to inhibit, request with a low start bit, then present
// data, parity and stop on successive device clock falling edges.
// tx_complete pulses once the device has acknowledged the byte.

`timescale 1ns/1ps
`default_nettype none

module ps2_tx (
    input  wire        clk,
    input  wire        reset,
    input  wire  [7:0] tx_byte,
    input  wire        start_tx,
    input  wire        clk_fall,
    input  wire        data_filt,
    output logic       ps2_clk_oe,
    output logic       ps2_data_oe,
    output logic       tx_busy,
    output logic       tx_complete
);

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_INHIBIT,
        TX_REQUEST,
        TX_DATA,
        TX_PARITY,
        TX_STOP,
        TX_ACK
    } tx_state_t;

    tx_state_t                     state;
    logic [ps2_pkg::INHIBIT_W-1:0] inhibit_cnt;
    logic [2:0]                    bit_idx;
    logic [7:0]                    byte_q;
    logic                          parity_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= TX_IDLE;
            inhibit_cnt <= '0;
            bit_idx     <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (start_tx) begin
                        state       <= TX_INHIBIT;
                        inhibit_cnt <= '0;
                    end
                end
                TX_INHIBIT: begin
                    if (inhibit_cnt == ps2_pkg::INHIBIT_CYCLES - 1)
                        state <= TX_REQUEST;
                    else
                        inhibit_cnt <= inhibit_cnt + 1'b1;
                end
                TX_REQUEST: begin
                    // the first device clock asks for data bit 0
                    if (clk_fall) begin
                        state   <= TX_DATA;
                        bit_idx <= '0;
                    end
                end
                TX_DATA: begin
                    if (clk_fall) begin
                        if (bit_idx == 3'd7)
                            state <= TX_PARITY;
                        else
                            bit_idx <= bit_idx + 1'b1;
                    end
                end
                TX_PARITY: begin
                    if (clk_fall)
                        state <= TX_STOP;
                end
                TX_STOP: begin
                    // the device pulls data low after taking the stop bit
                    // without it we drop back to idle and the sender may retry
                    if (clk_fall)
                        state <= data_filt ? TX_IDLE : TX_ACK;
                end
                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

    // the command byte and its odd parity are captured when the send starts
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && start_tx) begin
            byte_q   <= tx_byte;
            parity_q <= ~^tx_byte;
        end
    end

    // an enable of 1 pulls the line low, so a 0 bit drives the enable high
    always_comb begin
        ps2_clk_oe = state == TX_INHIBIT;
        case (state)
            TX_REQUEST: ps2_data_oe = 1'b1;
            TX_DATA:    ps2_data_oe = ~byte_q[bit_idx];
            TX_PARITY:  ps2_data_oe = ~parity_q;
            default:    ps2_data_oe = 1'b0;
        endcase
    end

    assign tx_busy     = state != TX_IDLE && state != TX_ACK;
    assign tx_complete = state == TX_ACK;

endmodule

`default_nettype wire

//--- verilog/scancode_translator.sv
// Set-2 to set-1 scancode lookup, purely combinational.
// Codes outside the table, the prefixes included, give kbd_pkg::SC1_NONE.

`timescale 1ns/1ps
`default_nettype none

module scancode_translator (
    input  wire  [7:0] scancode_in,
    output logic [7:0] scancode_out
);

    always_comb begin
        case (scancode_in)
            // letters
            8'h1C: scancode_out = 8'h1E;
            8'h32: scancode_out = 8'h30;
            8'h21: scancode_out = 8'h2E;
            8'h23: scancode_out = 8'h20;
            8'h24: scancode_out = 8'h12;
            8'h2B: scancode_out = 8'h21;
            8'h34: scancode_out = 8'h22;
            8'h33: scancode_out = 8'h23;
            8'h43: scancode_out = 8'h17;
            8'h3B: scancode_out = 8'h24;
            8'h42: scancode_out = 8'h25;
            8'h4B: scancode_out = 8'h26;
            8'h3A: scancode_out = 8'h32;
            8'h31: scancode_out = 8'h31;
            8'h44: scancode_out = 8'h18;
            8'h4D: scancode_out = 8'h19;
            8'h15: scancode_out = 8'h10;
            8'h2D: scancode_out = 8'h13;
            8'h1B: scancode_out = 8'h1F;
            8'h2C: scancode_out = 8'h14;
            8'h3C: scancode_out = 8'h16;
            8'h2A: scancode_out = 8'h2F;
            8'h1D: scancode_out = 8'h11;
            8'h22: scancode_out = 8'h2D;
            8'h35: scancode_out = 8'h15;
            8'h1A: scancode_out = 8'h2C;
            // top row digits 1 to 0
            8'h16: scancode_out = 8'h02;
            8'h1E: scancode_out = 8'h03;
            8'h26: scancode_out = 8'h04;
            8'h25: scancode_out = 8'h05;
            8'h2E: scancode_out = 8'h06;
            8'h36: scancode_out = 8'h07;
            8'h3D: scancode_out = 8'h08;
            8'h3E: scancode_out = 8'h09;
            8'h46: scancode_out = 8'h0A;
            8'h45: scancode_out = 8'h0B;
            // space, enter, escape, backspace and tab
            8'h29: scancode_out = 8'h39;
            8'h5A: scancode_out = 8'h1C;
            8'h76: scancode_out = 8'h01;
            8'h66: scancode_out = 8'h0E;
            8'h0D: scancode_out = 8'h0F;
            // shifts, left ctrl, left alt and caps lock
            8'h12: scancode_out = 8'h2A;
            8'h59: scancode_out = 8'h36;
            8'h14: scancode_out = 8'h1D;
            8'h11: scancode_out = 8'h38;
            8'h58: scancode_out = 8'h3A;
            default: scancode_out = kbd_pkg::SC1_NONE;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/keyboard_controller.sv
// Keyboard power-up sequencer and set-1 scancode source.
// Sends reset and waits for the self-test pass, then sends enable and waits
// for its acknowledge. After that every translated make or break is output
// as a one-cycle scancode_valid strobe.

`timescale 1ns/1ps
`default_nettype none

module keyboard_controller (
    input  wire        clk,
    input  wire        reset,
    input  wire  [7:0] rx_byte,
    input  wire        rx_valid,
    input  wire        tx_complete,
    input  wire        tx_busy,
    output logic [7:0] tx_byte,
    output logic       start_tx,
    output logic [7:0] scancode,
    output logic       scancode_valid
);

    typedef enum logic [2:0] {
        ST_RESET_START,
        ST_RESET_WAIT,
        ST_ENABLE_START,
        ST_ENABLE_WAIT,
        ST_IDLE
    } kbd_state_t;

    kbd_state_t state;
    kbd_state_t next_state;
    logic [7:0] translated;
    // the previous received byte was the release prefix
    logic       is_break;

    scancode_translator u_translator (
        .scancode_in  (rx_byte),
        .scancode_out (translated)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            state <= ST_RESET_START;
        else
            state <= next_state;
    end

    // an extended release is E0 F0 code, so only the byte just before counts
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            is_break <= 1'b0;
        else if (rx_valid)
            is_break <= rx_byte == kbd_pkg::SC_BREAK;
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_RESET_START:
                if (tx_complete) next_state = ST_RESET_WAIT;
            // the reset acknowledge comes first and is skipped here
            ST_RESET_WAIT:
                if (rx_valid && rx_byte == kbd_pkg::RSP_BAT_OK) next_state = ST_ENABLE_START;
            ST_ENABLE_START:
                if (tx_complete) next_state = ST_ENABLE_WAIT;
            ST_ENABLE_WAIT:
                if (rx_valid) next_state = ST_IDLE;
            default:
                next_state = ST_IDLE;
        endcase
    end

    // a start is held off while the transmitter is busy or just finishing
    always_comb begin
        start_tx = 1'b0;
        tx_byte  = 8'h00;
        case (state)
            ST_RESET_START: begin
                start_tx = ~tx_busy & ~tx_complete;
                tx_byte  = kbd_pkg::CMD_RESET;
            end
            ST_ENABLE_START: begin
                start_tx = ~tx_busy & ~tx_complete;
                tx_byte  = kbd_pkg::CMD_ENABLE;
            end
            default: begin
                start_tx = 1'b0;
                tx_byte  = 8'h00;
            end
        endcase
    end

    assign scancode = is_break ? (kbd_pkg::BREAK_FLAG | translated) : translated;

    // prefixes and unknown codes never reach the CPU
    assign scancode_valid = state == ST_IDLE && rx_valid &&
                            rx_byte != kbd_pkg::SC_BREAK &&
                            rx_byte != kbd_pkg::SC_EXT &&
                            translated != kbd_pkg::SC1_NONE;

endmodule

`default_nettype wire

//--- verilog/ps2_keyboard_top.sv
// PS/2 keyboard subsystem top level.
// The oe outputs pull the open-drain pins low when high, the pull-ups sit outside.
// scancode is valid only in the cycle scancode_valid is high.

`timescale 1ns/1ps
`default_nettype none

module ps2_keyboard_top (
    input  wire        clk,
    input  wire        reset,
    input  wire        ps2_clk_in,
    input  wire        ps2_data_in,
    output logic       ps2_clk_oe,
    output logic       ps2_data_oe,
    output logic [7:0] scancode,
    output logic       scancode_valid
);

    logic       clk_fall;
    logic       data_filt;
    logic [7:0] rx_byte;
    logic       rx_valid;
    logic [7:0] tx_byte;
    logic       start_tx;
    logic       tx_busy;
    logic       tx_complete;

    // the filtered clock level itself has no user here, only its falling edge
    ps2_line_filter u_filter (
        .clk         (clk),
        .reset       (reset),
        .ps2_clk_in  (ps2_clk_in),
        .ps2_data_in (ps2_data_in),
        .clk_filt    (),
        .data_filt   (data_filt),
        .clk_fall    (clk_fall)
    );

    // the receiver is held off for the whole of a host transmission
    ps2_rx u_rx (
        .clk        (clk),
        .reset      (reset),
        .clk_fall   (clk_fall),
        .data_filt  (data_filt),
        .rx_inhibit (tx_busy),
        .rx_byte    (rx_byte),
        .rx_valid   (rx_valid)
    );

    ps2_tx u_tx (
        .clk         (clk),
        .reset       (reset),
        .tx_byte     (tx_byte),
        .start_tx    (start_tx),
        .clk_fall    (clk_fall),
        .data_filt   (data_filt),
        .ps2_clk_oe  (ps2_clk_oe),
        .ps2_data_oe (ps2_data_oe),
        .tx_busy     (tx_busy),
        .tx_complete (tx_complete)
    );

    keyboard_controller u_ctrl (
        .clk            (clk),
        .reset          (reset),
        .rx_byte        (rx_byte),
        .rx_valid       (rx_valid),
        .tx_complete    (tx_complete),
        .tx_busy        (tx_busy),
        .tx_byte        (tx_byte),
        .start_tx       (start_tx),
        .scancode       (scancode),
        .scancode_valid (scancode_valid)
    );

endmodule

`default_nettype wire

//--- bench/ps2_keyboard_model.sv
// Behavioral PS/2 keyboard used by the testbench.
// It pulls the shared lines low through clk_low and data_low and reads them back.
// serve_command takes one host command and answers it, send_frame sends one byte.

`timescale 1ns/1ps
`default_nettype none

module ps2_keyboard_model (
    input  wire  clk,
    input  wire  ps2_clk,
    input  wire  ps2_data,
    output logic clk_low,
    output logic data_low
);

    // system clocks per half period of the keyboard clock
    localparam int HALF = 20;
    localparam int REQ_TIMEOUT = 4000;

    // every host command taken, with the result of its odd parity check
    logic [7:0] cmd_log [0:7];
    logic       par_ok_log [0:7];
    int         cmd_count;

    initial begin
        clk_low   = 1'b0;
        data_low  = 1'b0;
        cmd_count = 0;
    end

    // line changes land 1 ns after a rising system clock
    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // start bit, 8 data bits LSB first, odd parity and stop
    // the host samples each bit on the falling edge of the keyboard clock
    task automatic send_frame(input logic [7:0] value, input bit bad_parity);
        logic [10:0] bits;
        bits = {1'b1, (~^value) ^ bad_parity, value, 1'b0};
        for (int i = 0; i < 11; i++) begin
            data_low = ~bits[i];
            idle_cycles(HALF);
            clk_low = 1'b1;
            idle_cycles(HALF);
            clk_low = 1'b0;
        end
        data_low = 1'b0;
        idle_cycles(2 * HALF);
    endtask

    task automatic serve_command(output bit seen);
        int         waited;
        logic [9:0] bits;
        logic [7:0] cmd;
        seen   = 1'b0;
        waited = 0;
        // the host inhibits with the clock low, then requests with data low
        while (ps2_clk && ps2_data && waited < REQ_TIMEOUT) begin
            idle_cycles(1);
            waited++;
        end
        while (!(ps2_clk && !ps2_data) && waited < REQ_TIMEOUT) begin
            idle_cycles(1);
            waited++;
        end
        if (waited < REQ_TIMEOUT) begin
            seen = 1'b1;
            idle_cycles(HALF);
            // data, parity and stop are read just before each rising edge
            for (int i = 0; i < 10; i++) begin
                clk_low = 1'b1;
                idle_cycles(HALF);
                bits[i] = ps2_data;
                clk_low = 1'b0;
                idle_cycles(HALF);
            end
            // the acknowledge holds data low across one more clock pulse
            data_low = 1'b1;
            idle_cycles(HALF);
            clk_low = 1'b1;
            idle_cycles(HALF);
            clk_low  = 1'b0;
            data_low = 1'b0;
            cmd = bits[7:0];
            if (cmd_count < 8) begin
                cmd_log[cmd_count]    = cmd;
                par_ok_log[cmd_count] = ^bits[8:0];
            end
            cmd_count++;
            idle_cycles(2 * HALF);
            // reset gets an acknowledge and then the self-test result
            if (cmd == kbd_pkg::CMD_RESET) begin
                send_frame(kbd_pkg::RSP_ACK, 1'b0);
                send_frame(kbd_pkg::RSP_BAT_OK, 1'b0);
            end else if (cmd == kbd_pkg::CMD_ENABLE) begin
                send_frame(kbd_pkg::RSP_ACK, 1'b0);
            end
        end
    endtask

endmodule

`default_nettype wire

//--- bench/tb_ps2_keyboard.sv
// Testbench for the PS/2 keyboard subsystem.
// Runs the power-up exchange against a behavioral keyboard, then sends makes,
// breaks, extended keys, a bad frame and a seeded random stream, and checks
// each scancode_valid pulse against a queue of expected set-1 codes.

`timescale 1ns/1ps
`default_nettype none

module tb_ps2_keyboard;

    localparam int DRAIN_TIMEOUT = 2000;
    // the six reference keys as packed bytes with entry 0 in the low byte
    localparam logic [47:0] SET2_KEYS = 48'h29_76_5A_21_32_1C;
    localparam logic [47:0] SET1_KEYS = 48'h39_01_1C_2E_30_1E;

    logic       clk;
    logic       reset;
    wire        ps2_clk;
    wire        ps2_data;
    logic       ps2_clk_oe;
    logic       ps2_data_oe;
    logic       kbd_clk_low;
    logic       kbd_data_low;
    logic [7:0] scancode;
    logic       scancode_valid;

    logic [7:0] expected_q [$];
    logic [7:0] exp_code;
    int         cmd_ack_count;
    integer     seed;
    int         idx;
    bit         brk;
    bit         seen;

    // each open-drain line is pulled up and goes low when either side pulls it
    assign ps2_clk  = ~(ps2_clk_oe | kbd_clk_low);
    assign ps2_data = ~(ps2_data_oe | kbd_data_low);

    ps2_keyboard_top DUT (
        .clk            (clk),
        .reset          (reset),
        .ps2_clk_in     (ps2_clk),
        .ps2_data_in    (ps2_data),
        .ps2_clk_oe     (ps2_clk_oe),
        .ps2_data_oe    (ps2_data_oe),
        .scancode       (scancode),
        .scancode_valid (scancode_valid)
    );

    ps2_keyboard_model kbd (
        .clk      (clk),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .clk_low  (kbd_clk_low),
        .data_low (kbd_data_low)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run();
        $display("** FAIL **");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at t=%0t: %s", $time, msg);
        stop_run();
    endtask

    task automatic fail_value(input string name, input logic [7:0] exp, input logic [7:0] act);
        $display("FAIL t=%0t %s expected 0x%02h got 0x%02h", $time, name, exp, act);
        stop_run();
    endtask

    // the DUT outputs only move just after a rising edge
    // so every pulse is checked on the falling edge
    always @(negedge clk) begin
        if (!reset && scancode_valid) begin
            assert (expected_q.size() != 0)
                else report_error("scancode_valid pulsed with no scancode expected");
            exp_code = expected_q.pop_front();
            assert (scancode == exp_code) else fail_value("scancode", exp_code, scancode);
        end
        if (!reset && DUT.u_tx.tx_complete)
            cmd_ack_count++;
    end

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        assert (expected_q.size() == 0)
            else report_error("timed out waiting for a scancode_valid pulse");
    endtask

    // one make of reference key idx, or its break when brk is set
    task automatic press_key(input int idx, input bit brk);
        logic [7:0] value;
        value = SET1_KEYS[8*idx +: 8];
        if (brk) begin
            // the release prefix gives no pulse of its own
            kbd.send_frame(kbd_pkg::SC_BREAK, 1'b0);
            value = value | kbd_pkg::BREAK_FLAG;
        end
        expected_q.push_back(value);
        kbd.send_frame(SET2_KEYS[8*idx +: 8], 1'b0);
        wait_drained();
    endtask

    initial begin
        seed          = 67;
        cmd_ack_count = 0;
        reset         = 1'b1;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;

        // power-up sends reset and then enable and the keyboard acknowledges each
        kbd.serve_command(seen);
        assert (seen) else report_error("no reset command request from the DUT");
        kbd.serve_command(seen);
        assert (seen) else report_error("no enable command request from the DUT");
        assert (kbd.cmd_count == 2) else report_error("wrong number of host commands");
        assert (kbd.cmd_log[0] == kbd_pkg::CMD_RESET)
            else fail_value("host command 0", kbd_pkg::CMD_RESET, kbd.cmd_log[0]);
        assert (kbd.cmd_log[1] == kbd_pkg::CMD_ENABLE)
            else fail_value("host command 1", kbd_pkg::CMD_ENABLE, kbd.cmd_log[1]);
        assert (kbd.par_ok_log[0] && kbd.par_ok_log[1])
            else report_error("a host command arrived with bad parity");
        assert (cmd_ack_count == 2) else report_error("the DUT missed a command acknowledge");

        for (int i = 0; i < 6; i++)
            press_key(i, 1'b0);
        for (int i = 0; i < 6; i++)
            press_key(i, 1'b1);
        // an extended make and then an extended release
        kbd.send_frame(kbd_pkg::SC_EXT, 1'b0);
        press_key(3, 1'b0);
        kbd.send_frame(kbd_pkg::SC_EXT, 1'b0);
        press_key(4, 1'b1);
        // a corrupted frame is dropped and the next one still decodes
        kbd.send_frame(SET2_KEYS[15:8], 1'b1);
        press_key(1, 1'b0);

        for (int n = 0; n < 40; n++) begin
            idx = $unsigned($random(seed)) % 6;
            brk = $random(seed) & 1;
            press_key(idx, brk);
        end
        wait_drained();
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
verilog/ps2_pkg.sv
verilog/kbd_pkg.sv
verilog/ps2_line_filter.sv
verilog/ps2_rx.sv
verilog/ps2_tx.sv
verilog/scancode_translator.sv
verilog/keyboard_controller.sv
verilog/ps2_keyboard_top.sv
bench/ps2_keyboard_model.sv
bench/tb_ps2_keyboard.sv
